//--- src/cpu_settings.svh
// CPU core settings
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data bus and register width
`define DATA_W 8

// Address bus width, two data words
`define ADDR_W 16

// Reset vector, low byte first
`define RESET_VEC_LO 16'hFFFC
`define RESET_VEC_HI 16'hFFFD

`endif

//--- src/cpuPkg.sv
// CPU core types
`include "cpu_settings.svh"

package cpuPkg;

	// Supported 6502 opcodes
	typedef enum logic [`DATA_W-1:0] {
		opLdaImm = 8'hA9,
		opLdaAbs = 8'hAD,
		opLdxImm = 8'hA2,
		opLdxAbs = 8'hAE,
		opLdyImm = 8'hA0,
		opLdyAbs = 8'hAC,
		opStaAbs = 8'h8D,
		opStxAbs = 8'h8E,
		opStyAbs = 8'h8C,
		opAdcImm = 8'h69,
		opInx    = 8'hE8,
		opIny    = 8'hC8,
		opBpl    = 8'h10,
		opBmi    = 8'h30,
		opBvc    = 8'h50,
		opBvs    = 8'h70,
		opBcc    = 8'h90,
		opBcs    = 8'hB0,
		opBne    = 8'hD0,
		opBeq    = 8'hF0,
		opClc    = 8'h18,
		opSec    = 8'h38,
		opClv    = 8'hB8,
		opNop    = 8'hEA,
		opJmpAbs = 8'h4C
	} opcodeT;

	typedef enum logic [1:0] {stReset, stVecLo, stVecHi, stRun} ctrlStateT;

	typedef enum logic [1:0] {aluPass, aluAdd, aluInc, aluDec} aluOpT;

	typedef enum logic [1:0] {regNone, regA, regX, regY} regSelT;

	typedef enum logic {addrPc, addrDl} addrSelT;

	// ALU operand sources
	typedef enum logic [2:0] {
		aluInData, aluInA, aluInX, aluInY, aluInPcLo, aluInPcHi
	} aluInSelT;

endpackage

//--- src/microcodeCtrl.sv
// Microcode controller
`timescale 1ns/10ps
`include "cpu_settings.svh"

module microcodeCtrl (
	input  logic               clk,
	input  logic               rstN,
	input  logic [`DATA_W-1:0] dataIn,
	input  logic               flagN,
	input  logic               flagV,
	input  logic               flagZ,
	input  logic               flagC,
	input  logic               branchCarry,
	input  logic               offsetNeg,
	output cpuPkg::aluOpT      aluOp,
	output cpuPkg::aluInSelT   aluInSel,
	output cpuPkg::regSelT     regWrSel,
	output cpuPkg::regSelT     storeSel,
	output cpuPkg::addrSelT    addrSel,
	output logic               updNZ,
	output logic               updCV,
	output logic               setC,
	output logic               clrC,
	output logic               clrV,
	output logic               pcInc,
	output logic               pcLoadDl,
	output logic               pcLoadLo,
	output logic               pcHiAdj,
	output logic               dlLoLoad,
	output logic               dlHiLoad,
	output logic               we,
	output logic               sync
);
	import cpuPkg::*;

	ctrlStateT state;
	opcodeT    ir;
	// One-hot instruction cycle, bit 0 is the opcode fetch
	logic [3:0] cycle;
	logic       lastCycle;
	logic       branchTaken;
	regSelT     regTarget;

	// Branch condition from the flags
	always_comb begin
		case (ir)
			opBpl:   branchTaken = !flagN;
			opBmi:   branchTaken = flagN;
			opBvc:   branchTaken = !flagV;
			opBvs:   branchTaken = flagV;
			opBcc:   branchTaken = !flagC;
			opBcs:   branchTaken = flagC;
			opBne:   branchTaken = !flagZ;
			opBeq:   branchTaken = flagZ;
			default: branchTaken = 1'b0;
		endcase
	end

	// Register named by a load or store
	always_comb begin
		case (ir)
			opLdaImm, opLdaAbs, opStaAbs: regTarget = regA;
			opLdxImm, opLdxAbs, opStxAbs: regTarget = regX;
			opLdyImm, opLdyAbs, opStyAbs: regTarget = regY;
			default:                      regTarget = regNone;
		endcase
	end

	always_comb begin
		aluOp     = aluPass;
		aluInSel  = aluInData;
		regWrSel  = regNone;
		storeSel  = regNone;
		addrSel   = addrPc;
		updNZ     = 1'b0;
		updCV     = 1'b0;
		setC      = 1'b0;
		clrC      = 1'b0;
		clrV      = 1'b0;
		pcInc     = 1'b0;
		pcLoadDl  = 1'b0;
		pcLoadLo  = 1'b0;
		pcHiAdj   = 1'b0;
		dlLoLoad  = 1'b0;
		dlHiLoad  = 1'b0;
		we        = 1'b0;
		sync      = 1'b0;
		lastCycle = 1'b0;
		case (state)
			stVecLo: begin
				dlLoLoad = 1'b1;
				pcInc    = 1'b1;
			end
			stVecHi: pcLoadDl = 1'b1;
			stRun: begin
				if (cycle[0]) begin
					sync  = 1'b1;
					pcInc = 1'b1;
				end else begin
					case (ir)
						opLdaImm, opLdxImm, opLdyImm: begin
							regWrSel  = regTarget;
							updNZ     = 1'b1;
							pcInc     = 1'b1;
							lastCycle = 1'b1;
						end
						opAdcImm: begin
							aluOp     = aluAdd;
							regWrSel  = regA;
							updNZ     = 1'b1;
							updCV     = 1'b1;
							pcInc     = 1'b1;
							lastCycle = 1'b1;
						end
						opLdaAbs, opLdxAbs, opLdyAbs: begin
							if (cycle[1]) begin
								dlLoLoad = 1'b1;
								pcInc    = 1'b1;
							end else if (cycle[2]) begin
								dlHiLoad = 1'b1;
								pcInc    = 1'b1;
							end else begin
								addrSel   = addrDl;
								regWrSel  = regTarget;
								updNZ     = 1'b1;
								lastCycle = 1'b1;
							end
						end
						opStaAbs, opStxAbs, opStyAbs: begin
							if (cycle[1]) begin
								dlLoLoad = 1'b1;
								pcInc    = 1'b1;
							end else if (cycle[2]) begin
								dlHiLoad = 1'b1;
								pcInc    = 1'b1;
							end else begin
								addrSel   = addrDl;
								storeSel  = regTarget;
								we        = 1'b1;
								lastCycle = 1'b1;
							end
						end
						opInx, opIny: begin
							aluOp     = aluInc;
							aluInSel  = (ir == opInx) ? aluInX : aluInY;
							regWrSel  = (ir == opInx) ? regX : regY;
							updNZ     = 1'b1;
							lastCycle = 1'b1;
						end
						opBpl, opBmi, opBvc, opBvs, opBcc, opBcs, opBne, opBeq: begin
							if (cycle[1]) begin
								// Offset byte goes to the low data latch
								dlLoLoad  = 1'b1;
								pcInc     = 1'b1;
								lastCycle = !branchTaken;
							end else if (cycle[2]) begin
								pcLoadLo  = 1'b1;
								// Page crossed when carry and offset sign differ
								lastCycle = !(branchCarry ^ offsetNeg);
							end else begin
								aluInSel  = aluInPcHi;
								aluOp     = offsetNeg ? aluDec : aluInc;
								pcHiAdj   = 1'b1;
								lastCycle = 1'b1;
							end
						end
						opJmpAbs: begin
							if (cycle[1]) begin
								dlLoLoad = 1'b1;
								pcInc    = 1'b1;
							end else begin
								pcLoadDl  = 1'b1;
								lastCycle = 1'b1;
							end
						end
						opClc: begin
							clrC      = 1'b1;
							lastCycle = 1'b1;
						end
						opSec: begin
							setC      = 1'b1;
							lastCycle = 1'b1;
						end
						opClv: begin
							clrV      = 1'b1;
							lastCycle = 1'b1;
						end
						// NOP and unknown opcodes are one byte, two cycles
						default: lastCycle = 1'b1;
					endcase
				end
			end
			default: begin
				// Idle reset cycle, all strobes low
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= stReset;
			cycle <= 4'b0001;
			ir    <= opNop;
		end else begin
			case (state)
				stReset: state <= stVecLo;
				stVecLo: state <= stVecHi;
				default: state <= stRun;
			endcase
			if (state == stRun) begin
				if (cycle[0]) begin
					ir <= opcodeT'(dataIn);
				end
				if (lastCycle) begin
					cycle <= 4'b0001;
				end else begin
					cycle <= {cycle[2:0], 1'b0};
				end
			end
		end
	end

endmodule

//--- src/regFile.sv
// Register file
`timescale 1ns/10ps
`include "cpu_settings.svh"

module regFile (
	input  logic               clk,
	input  logic               rstN,
	input  cpuPkg::regSelT     regWrSel,
	input  logic [`DATA_W-1:0] aluResult,
	input  cpuPkg::regSelT     storeSel,
	output logic [`DATA_W-1:0] regA,
	output logic [`DATA_W-1:0] regX,
	output logic [`DATA_W-1:0] regY,
	output logic [`DATA_W-1:0] dataOut
);

	// Select values share their names with the register ports
	always_ff @(posedge clk) begin
		if (!rstN) begin
			regA <= '0;
			regX <= '0;
			regY <= '0;
		end else begin
			case (regWrSel)
				cpuPkg::regA: regA <= aluResult;
				cpuPkg::regX: regX <= aluResult;
				cpuPkg::regY: regY <= aluResult;
				default:      ;
			endcase
		end
	end

	// Store data onto the bus
	always_comb begin
		case (storeSel)
			cpuPkg::regA: dataOut = regA;
			cpuPkg::regX: dataOut = regX;
			cpuPkg::regY: dataOut = regY;
			default:      dataOut = '0;
		endcase
	end

endmodule

//--- src/alu.sv
// Arithmetic logic unit
`timescale 1ns/10ps
`include "cpu_settings.svh"

module alu (
	input  cpuPkg::aluOpT      aluOp,
	input  cpuPkg::aluInSelT   aluInSel,
	input  logic [`DATA_W-1:0] dataIn,
	input  logic [`DATA_W-1:0] regA,
	input  logic [`DATA_W-1:0] regX,
	input  logic [`DATA_W-1:0] regY,
	input  logic [`DATA_W-1:0] pcLo,
	input  logic [`DATA_W-1:0] pcHi,
	input  logic               carryIn,
	output logic [`DATA_W-1:0] aluResult,
	output logic               carryOut,
	output logic               overflowOut,
	output logic               zeroOut,
	output logic               negOut
);
	import cpuPkg::*;

	logic [`DATA_W-1:0] operand;
	logic [`DATA_W:0]   sum;

	// Operand select
	always_comb begin
		case (aluInSel)
			aluInA:    operand = regA;
			aluInX:    operand = regX;
			aluInY:    operand = regY;
			aluInPcLo: operand = pcLo;
			aluInPcHi: operand = pcHi;
			default:   operand = dataIn;
		endcase
	end

	// Binary add with A, no decimal mode
	assign sum = {1'b0, operand} + {1'b0, regA} + {{`DATA_W{1'b0}}, carryIn};

	always_comb begin
		carryOut    = 1'b0;
		overflowOut = 1'b0;
		case (aluOp)
			aluAdd: begin
				aluResult = sum[`DATA_W-1:0];
				carryOut  = sum[`DATA_W];
				// Signed overflow when both inputs share a sign the result lacks
				overflowOut = (operand[`DATA_W-1] == regA[`DATA_W-1]) &&
					(sum[`DATA_W-1] != regA[`DATA_W-1]);
			end
			aluInc:  aluResult = operand + 1'b1;
			aluDec:  aluResult = operand - 1'b1;
			default: aluResult = operand;
		endcase
	end

	assign zeroOut = (aluResult == '0);
	assign negOut  = aluResult[`DATA_W-1];

endmodule

//--- src/statusReg.sv
// Processor status flags
`timescale 1ns/10ps

module statusReg (
	input  logic clk,
	input  logic rstN,
	input  logic updNZ,
	input  logic updCV,
	input  logic setC,
	input  logic clrC,
	input  logic clrV,
	input  logic zeroIn,
	input  logic negIn,
	input  logic carryIn,
	input  logic overflowIn,
	output logic flagN,
	output logic flagV,
	output logic flagZ,
	output logic flagC
);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			flagN <= 1'b0;
			flagV <= 1'b0;
			flagZ <= 1'b0;
			flagC <= 1'b0;
		end else begin
			if (updNZ) begin
				flagN <= negIn;
				flagZ <= zeroIn;
			end
			// Carry from ALU or from CLC/SEC
			if (updCV) begin
				flagC <= carryIn;
			end else if (setC) begin
				flagC <= 1'b1;
			end else if (clrC) begin
				flagC <= 1'b0;
			end
			if (updCV) begin
				flagV <= overflowIn;
			end else if (clrV) begin
				flagV <= 1'b0;
			end
		end
	end

endmodule

//--- src/addrUnit.sv
// Address unit
`timescale 1ns/10ps
`include "cpu_settings.svh"

module addrUnit (
	input  logic               clk,
	input  logic               rstN,
	input  logic [`DATA_W-1:0] dataIn,
	input  logic [`DATA_W-1:0] aluResult,
	input  cpuPkg::addrSelT    addrSel,
	input  logic               pcInc,
	input  logic               pcLoadDl,
	input  logic               pcLoadLo,
	input  logic               pcHiAdj,
	input  logic               dlLoLoad,
	input  logic               dlHiLoad,
	output logic [`ADDR_W-1:0] addr,
	output logic [`DATA_W-1:0] pcLo,
	output logic [`DATA_W-1:0] pcHi,
	output logic               branchCarry,
	output logic               offsetNeg
);
	import cpuPkg::*;

	logic [`ADDR_W-1:0] pc;
	logic [`DATA_W-1:0] dlLo;
	logic [`DATA_W-1:0] dlHi;
	logic [`DATA_W:0]   branchSum;

	assign pcLo = pc[`DATA_W-1:0];
	assign pcHi = pc[`ADDR_W-1:`DATA_W];

	// Branch offset into PC low, carry tells the controller about page crossing
	assign branchSum   = {1'b0, pcLo} + {1'b0, dlLo};
	assign branchCarry = branchSum[`DATA_W];
	assign offsetNeg   = dlLo[`DATA_W-1];

	assign addr = (addrSel == addrDl) ? {dlHi, dlLo} : pc;

	// Program counter
	// Starts on the reset vector so the controller can walk through it
	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= `RESET_VEC_LO;
		end else if (pcLoadDl) begin
			// High byte comes straight off the bus
			pc <= {dataIn, dlLo};
		end else if (pcLoadLo) begin
			pc[`DATA_W-1:0] <= branchSum[`DATA_W-1:0];
		end else if (pcHiAdj) begin
			pc[`ADDR_W-1:`DATA_W] <= aluResult;
		end else if (pcInc) begin
			pc <= pc + 1'b1;
		end
	end

	// Data latches for operand address and branch offset
	always_ff @(posedge clk) begin
		if (dlLoLoad) begin
			dlLo <= dataIn;
		end
		if (dlHiLoad) begin
			dlHi <= dataIn;
		end
	end

endmodule

//--- src/cpuCore.sv
// 6502 subset core
`timescale 1ns/10ps
`include "cpu_settings.svh"

module cpuCore (
	input  logic               clk,
	input  logic               rstN,
	input  logic [`DATA_W-1:0] dataIn,
	output logic [`ADDR_W-1:0] addr,
	output logic [`DATA_W-1:0] dataOut,
	output logic               we,
	output logic               sync
);
	import cpuPkg::*;

	aluOpT    aluOp;
	aluInSelT aluInSel;
	regSelT   regWrSel;
	regSelT   storeSel;
	addrSelT  addrSel;
	logic     updNZ;
	logic     updCV;
	logic     setC;
	logic     clrC;
	logic     clrV;
	logic     pcInc;
	logic     pcLoadDl;
	logic     pcLoadLo;
	logic     pcHiAdj;
	logic     dlLoLoad;
	logic     dlHiLoad;

	logic [`DATA_W-1:0] regA;
	logic [`DATA_W-1:0] regX;
	logic [`DATA_W-1:0] regY;
	logic [`DATA_W-1:0] aluResult;
	logic [`DATA_W-1:0] pcLo;
	logic [`DATA_W-1:0] pcHi;
	logic               carryOut;
	logic               overflowOut;
	logic               zeroOut;
	logic               negOut;
	logic               flagN;
	logic               flagV;
	logic               flagZ;
	logic               flagC;
	logic               branchCarry;
	logic               offsetNeg;

	microcodeCtrl microcodeCtrl_i (
		.clk(clk), .rstN(rstN), .dataIn(dataIn),
		.flagN(flagN), .flagV(flagV), .flagZ(flagZ), .flagC(flagC),
		.branchCarry(branchCarry), .offsetNeg(offsetNeg),
		.aluOp(aluOp), .aluInSel(aluInSel), .regWrSel(regWrSel), .storeSel(storeSel),
		.addrSel(addrSel), .updNZ(updNZ), .updCV(updCV), .setC(setC), .clrC(clrC),
		.clrV(clrV), .pcInc(pcInc), .pcLoadDl(pcLoadDl), .pcLoadLo(pcLoadLo),
		.pcHiAdj(pcHiAdj), .dlLoLoad(dlLoLoad), .dlHiLoad(dlHiLoad),
		.we(we), .sync(sync)
	);

	regFile regFile_i (
		.clk(clk), .rstN(rstN), .regWrSel(regWrSel), .aluResult(aluResult),
		.storeSel(storeSel), .regA(regA), .regX(regX), .regY(regY), .dataOut(dataOut)
	);

	alu alu_i (
		.aluOp(aluOp), .aluInSel(aluInSel), .dataIn(dataIn),
		.regA(regA), .regX(regX), .regY(regY), .pcLo(pcLo), .pcHi(pcHi),
		.carryIn(flagC), .aluResult(aluResult), .carryOut(carryOut),
		.overflowOut(overflowOut), .zeroOut(zeroOut), .negOut(negOut)
	);

	statusReg statusReg_i (
		.clk(clk), .rstN(rstN), .updNZ(updNZ), .updCV(updCV),
		.setC(setC), .clrC(clrC), .clrV(clrV),
		.zeroIn(zeroOut), .negIn(negOut), .carryIn(carryOut), .overflowIn(overflowOut),
		.flagN(flagN), .flagV(flagV), .flagZ(flagZ), .flagC(flagC)
	);

	addrUnit addrUnit_i (
		.clk(clk), .rstN(rstN), .dataIn(dataIn), .aluResult(aluResult),
		.addrSel(addrSel), .pcInc(pcInc), .pcLoadDl(pcLoadDl), .pcLoadLo(pcLoadLo),
		.pcHiAdj(pcHiAdj), .dlLoLoad(dlLoLoad), .dlHiLoad(dlHiLoad),
		.addr(addr), .pcLo(pcLo), .pcHi(pcHi),
		.branchCarry(branchCarry), .offsetNeg(offsetNeg)
	);

endmodule

//--- sim/testPrograms.svh
// Test program table
`ifndef TEST_PROGRAMS_SVH
`define TEST_PROGRAMS_SVH

// Program bytes sit right aligned in prog, the first byte is always an opcode
typedef struct packed {
	logic [15:0]  start;
	logic [127:0] prog;
	logic         presetEn;
	logic [15:0]  presetAddr;
	logic [7:0]   presetData;
	logic [1:0]   adcMode;
	logic [15:0]  expAddr;
	logic [7:0]   expData;
} progRowT;

// Random ADC rows take their expected store from the operands
localparam logic [1:0] adcFixed   = 2'd0;
localparam logic [1:0] adcByCarry = 2'd1;
localparam logic [1:0] adcByOvf   = 2'd2;

progRowT rows [0:39];
string   rowNames [0:39];
int      rowCount;
progRowT nextRow;

task automatic buildTable();
	rowCount = 0;
	clearNextRow();
	// Immediate loads stored back, vector moved around
	startAt(16'hC0DE);
	addRow("ldaImm", 128'hA9_42_8D_00_04, 16'h0400, 8'h42);
	startAt(16'h1234);
	addRow("ldxImm", 128'hA2_81_8E_00_04, 16'h0400, 8'h81);
	addRow("ldyImm", 128'hA0_3C_8C_00_04, 16'h0400, 8'h3C);
	// Absolute loads from a preset byte
	presetByte(16'h0500, 8'h5A);
	addRow("ldaAbs", 128'hAD_00_05_8D_00_04, 16'h0400, 8'h5A);
	presetByte(16'h0533, 8'hC7);
	addRow("ldxAbs", 128'hAE_33_05_8E_10_04, 16'h0410, 8'hC7);
	presetByte(16'h06FF, 8'h01);
	addRow("ldyAbs", 128'hAC_FF_06_8C_20_04, 16'h0420, 8'h01);
	// Operands at bytes 2 and 4 get replaced, the flag picks 0400 or 0401
	useRandomAdc(adcByCarry);
	addRow("adcClcBcs", 128'h18_A9_00_69_00_B0_03_8D_01_04_8D_00_04, 16'h0000, 8'h00);
	useRandomAdc(adcByCarry);
	addRow("adcSecBcs", 128'h38_A9_00_69_00_B0_03_8D_01_04_8D_00_04, 16'h0000, 8'h00);
	useRandomAdc(adcByOvf);
	addRow("adcClcBvs", 128'h18_A9_00_69_00_70_03_8D_01_04_8D_00_04, 16'h0000, 8'h00);
	useRandomAdc(adcByOvf);
	addRow("adcSecBvs", 128'h38_A9_00_69_00_70_03_8D_01_04_8D_00_04, 16'h0000, 8'h00);
	addRow("adcOvf", 128'h18_A9_50_69_50_70_03_8D_01_04_8D_00_04, 16'h0400, 8'hA0);
	addRow("adcCarry", 128'h38_A9_FF_69_01_B0_03_8D_01_04_8D_00_04, 16'h0400, 8'h01);
	addRow("clv", 128'h18_A9_50_69_50_B8_70_03_8D_01_04_8D_00_04, 16'h0401, 8'hA0);
	// Wrap to zero, BEQ picks the address
	addRow("inxWrap", 128'hA2_FF_E8_F0_03_8E_01_04_8E_00_04, 16'h0400, 8'h00);
	addRow("inyWrap", 128'hA0_FF_C8_F0_03_8C_01_04_8C_00_04, 16'h0400, 8'h00);
	// Branches store 55 on fall through and AA when taken
	addRow("bplYes", 128'hA9_01_10_05_A9_55_8D_00_04_A9_AA_8D_00_04, 16'h0400, 8'hAA);
	addRow("bplNo", 128'hA9_80_10_05_A9_55_8D_00_04_A9_AA_8D_00_04, 16'h0400, 8'h55);
	addRow("bmiYes", 128'hA9_80_30_05_A9_55_8D_00_04_A9_AA_8D_00_04, 16'h0400, 8'hAA);
	addRow("bmiNo", 128'hA9_01_30_05_A9_55_8D_00_04_A9_AA_8D_00_04, 16'h0400, 8'h55);
	addRow("bvcYes", 128'hB8_50_05_A9_55_8D_00_04_A9_AA_8D_00_04, 16'h0400, 8'hAA);
	addRow("bvcNo", 128'hA9_50_69_50_50_05_A9_55_8D_00_04_A9_AA_8D_00_04, 16'h0400, 8'h55);
	addRow("bvsYes", 128'hA9_50_69_50_70_05_A9_55_8D_00_04_A9_AA_8D_00_04, 16'h0400, 8'hAA);
	addRow("bvsNo", 128'hB8_70_05_A9_55_8D_00_04_A9_AA_8D_00_04, 16'h0400, 8'h55);
	addRow("bccYes", 128'h18_90_05_A9_55_8D_00_04_A9_AA_8D_00_04, 16'h0400, 8'hAA);
	addRow("bccNo", 128'h38_90_05_A9_55_8D_00_04_A9_AA_8D_00_04, 16'h0400, 8'h55);
	addRow("bcsYes", 128'h38_B0_05_A9_55_8D_00_04_A9_AA_8D_00_04, 16'h0400, 8'hAA);
	addRow("bcsNo", 128'h18_B0_05_A9_55_8D_00_04_A9_AA_8D_00_04, 16'h0400, 8'h55);
	addRow("bneYes", 128'hA9_01_D0_05_A9_55_8D_00_04_A9_AA_8D_00_04, 16'h0400, 8'hAA);
	addRow("bneNo", 128'hA9_00_D0_05_A9_55_8D_00_04_A9_AA_8D_00_04, 16'h0400, 8'h55);
	addRow("beqYes", 128'hA9_00_F0_05_A9_55_8D_00_04_A9_AA_8D_00_04, 16'h0400, 8'hAA);
	addRow("beqNo", 128'hA9_01_F0_05_A9_55_8D_00_04_A9_AA_8D_00_04, 16'h0400, 8'h55);
	// Page crossings around 0300
	startAt(16'h02F8);
	addRow("fwdCross", 128'h38_B0_05_A9_EE_8D_00_04_A9_C3_8D_00_04, 16'h0400, 8'hC3);
	startAt(16'h02F8);
	addRow("bwdCross", 128'h4C_00_03_A9_B5_8D_00_04_38_B0_F8_A9_EE_8D_00_04, 16'h0400, 8'hB5);
	// JMP over a store, then NOP and an unknown opcode
	addRow("jmpSkip", 128'h4C_08_02_A9_EE_8D_00_04_A9_77_8D_00_04, 16'h0400, 8'h77);
	addRow("nopSkip", 128'hA9_66_EA_02_8D_00_04, 16'h0400, 8'h66);
endtask

`endif

//--- sim/cpuCoreTb.sv
// CPU core testbench
`timescale 1ns/10ps
`include "cpu_settings.svh"

module cpuCoreTb;

	localparam int maxCycles = 200;
	localparam int memWords  = 1 << `ADDR_W;

	logic               clk = 1'b0;
	logic               rstN;
	logic [`DATA_W-1:0] dataIn;
	logic [`ADDR_W-1:0] addr;
	logic [`DATA_W-1:0] dataOut;
	logic               we;
	logic               sync;

	logic [`DATA_W-1:0] mem [0:memWords-1];

	`include "testPrograms.svh"

	progRowT            row;
	int                 idx;
	int                 cyc;
	int                 passCount;
	int                 failCount;
	logic               testOk;
	logic               seenSync;
	logic               gotWrite;
	logic [`ADDR_W-1:0] firstFetch;
	logic [`ADDR_W-1:0] wrAddr;
	logic [`DATA_W-1:0] wrData;
	logic [`ADDR_W-1:0] expAddr;
	logic [`DATA_W-1:0] expData;
	logic [31:0]        seedWord;

	always #50 clk = ~clk;

	cpuCore cpuCore_i (
		.clk(clk),
		.rstN(rstN),
		.dataIn(dataIn),
		.addr(addr),
		.dataOut(dataOut),
		.we(we),
		.sync(sync)
	);

	// Memory answers in the same cycle
	assign dataIn = mem[addr];

	always @(posedge clk) begin
		if (we) begin
			mem[addr] <= dataOut;
		end
	end

	task automatic clearNextRow();
		nextRow = '0;
		nextRow.start = 16'h0200;
	endtask

	task automatic startAt(input logic [15:0] start);
		nextRow.start = start;
	endtask

	task automatic presetByte(input logic [15:0] presetAddr, input logic [7:0] presetData);
		nextRow.presetEn   = 1'b1;
		nextRow.presetAddr = presetAddr;
		nextRow.presetData = presetData;
	endtask

	task automatic useRandomAdc(input logic [1:0] mode);
		nextRow.adcMode = mode;
	endtask

	task automatic addRow(input string name, input logic [127:0] prog,
			input logic [15:0] rowAddr, input logic [7:0] rowData);
		nextRow.prog    = prog;
		nextRow.expAddr = rowAddr;
		nextRow.expData = rowData;
		rows[rowCount]     = nextRow;
		rowNames[rowCount] = name;
		rowCount++;
		clearNextRow();
	endtask

	// Count of bytes up to the highest nonzero one
	function automatic int programLength(input logic [127:0] prog);
		int i;
		int len;
		len = 0;
		for (i = 15; i >= 0; i--) begin
			if (len == 0 && prog[8*i +: 8] != 8'h00) begin
				len = i + 1;
			end
		end
		return len;
	endfunction

	task automatic fillMemory();
		int i;
		for (i = 0; i < memWords; i++) begin
			mem[i] = i[7:0] ^ i[15:8] ^ 8'hA5;
		end
	endtask

	task automatic loadMemory(input progRowT r);
		int           i;
		int           len;
		logic [127:0] progBytes;
		progBytes = r.prog;
		len = programLength(progBytes);
		fillMemory();
		for (i = 0; i < len; i++) begin
			mem[r.start + i] = progBytes[8*(len-1-i) +: 8];
		end
		mem[`RESET_VEC_LO] = r.start[7:0];
		mem[`RESET_VEC_HI] = r.start[15:8];
		if (r.presetEn) begin
			mem[r.presetAddr] = r.presetData;
		end
	endtask

	// Binary ADC on random operands, carry in from CLC or SEC
	task automatic pickAdcOperands(input progRowT r, output logic [15:0] rowAddr,
			output logic [7:0] rowData);
		logic [31:0] rnd;
		logic [7:0]  opA;
		logic [7:0]  opB;
		logic        cin;
		logic [8:0]  sum;
		logic        ovf;
		rnd = $urandom;
		opA = rnd[7:0];
		opB = rnd[15:8];
		mem[r.start + 2] = opA;
		mem[r.start + 4] = opB;
		cin = (mem[r.start] == 8'h38);
		sum = {1'b0, opA} + {1'b0, opB} + {8'h00, cin};
		// Both inputs share a sign that the result lacks
		ovf = (opA[7] == opB[7]) && (sum[7] != opA[7]);
		rowData = sum[7:0];
		if (r.adcMode == adcByCarry) begin
			rowAddr = sum[8] ? 16'h0400 : 16'h0401;
		end else begin
			rowAddr = ovf ? 16'h0400 : 16'h0401;
		end
		$display("  ADC operands %h + %h + %0d", opA, opB, cin);
	endtask

	// Also notes the address of the first opcode fetch
	task automatic waitForWrite();
		seenSync = 1'b0;
		gotWrite = 1'b0;
		cyc = 0;
		while (!gotWrite && cyc < maxCycles) begin
			@(negedge clk);
			if (sync && !seenSync) begin
				seenSync   = 1'b1;
				firstFetch = addr;
			end
			if (we) begin
				gotWrite = 1'b1;
				wrAddr   = addr;
				wrData   = dataOut;
			end
			cyc++;
		end
	endtask

	initial begin
		rstN = 1'b0;
		fillMemory();
		passCount = 0;
		failCount = 0;
		seedWord = $urandom(50);
		buildTable();
		for (idx = 0; idx < rowCount; idx++) begin
			row = rows[idx];
			testOk = 1'b1;
			@(posedge clk);
			#1;
			rstN = 1'b0;
			@(posedge clk);
			#1;
			loadMemory(row);
			expAddr = row.expAddr;
			expData = row.expData;
			if (row.adcMode != adcFixed) begin
				pickAdcOperands(row, expAddr, expData);
			end
			@(posedge clk);
			#1;
			rstN = 1'b1;
			waitForWrite();
			assert (seenSync) else begin
				$display("Error at %0t: no opcode fetch after reset", $time);
				testOk = 1'b0;
			end
			if (seenSync) begin
				assert (firstFetch == row.start) else begin
					$display("Fail at %0t: addr at first fetch is %h, expected %h",
						$time, firstFetch, row.start);
					testOk = 1'b0;
				end
			end
			assert (gotWrite) else begin
				$display("Timeout at %0t: no write appeared within %0d cycles",
					$time, maxCycles);
				testOk = 1'b0;
			end
			if (gotWrite) begin
				assert (wrAddr == expAddr) else begin
					$display("Fail at %0t: addr is %h, expected %h", $time, wrAddr, expAddr);
					testOk = 1'b0;
				end
				assert (wrData == expData) else begin
					$display("Fail at %0t: dataOut is %h, expected %h", $time, wrData, expData);
					testOk = 1'b0;
				end
			end
			if (testOk) begin
				passCount++;
				$display("Test %0d %s: passed", idx, rowNames[idx]);
			end else begin
				failCount++;
				$display("Test %0d %s: failed", idx, rowNames[idx]);
			end
		end
		$display("Tests run: %0d, passed: %0d, failed: %0d", rowCount, passCount, failCount);
		if (failCount == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- tb.f
+incdir+src
+incdir+sim
src/cpuPkg.sv
src/microcodeCtrl.sv
src/regFile.sv
src/alu.sv
src/statusReg.sv
src/addrUnit.sv
src/cpuCore.sv
sim/cpuCoreTb.sv
